// ==== src/gfx_sp_isa_pkg.sv ====
package gfx_sp_isa_pkg;

	typedef logic [31:0] insn_word;

	// Opcode values outside this set are undefined.
	typedef enum logic [3:0] {
		SELECT = 4'h1,
		SWIZZL = 4'h2,
		BROADC = 4'h3,
		MATVEC = 4'h4,
		SEND   = 4'h8,
		RECV   = 4'h9
	} insn_op;

	// ========================================
	// Instruction fields
	// ========================================

	localparam int OP_HI    = 31;
	localparam int OP_LO    = 28;
	localparam int DST_HI   = 27;
	localparam int DST_LO   = 24;
	localparam int SRC_A_HI = 23;
	localparam int SRC_A_LO = 20;
	localparam int SRC_B_HI = 19;
	localparam int SRC_B_LO = 16;

	localparam int IMM_HI  = 15; // Broadcast immediate.
	localparam int IMM_LO  = 0;
	localparam int MASK_HI = 3;  // One select bit per lane.
	localparam int MASK_LO = 0;
	localparam int SWZ_HI  = 7;  // Two bits per lane.
	localparam int SWZ_LO  = 0;

	typedef logic [IMM_HI-IMM_LO:0]   broadc_imm;
	typedef logic [MASK_HI-MASK_LO:0] select_mask;
	typedef logic [SWZ_HI-SWZ_LO:0]   swizzle_op;

endpackage

// ==== src/gfx_sp_pipe_pkg.sv ====
package gfx_sp_pipe_pkg;

	localparam int NUM_REGS = 16;

	typedef logic [3:0] reg_idx;

	typedef enum logic [1:0] {
		stream,
		combiner,
		shuffler
	} ex_unit;

	// Operands for the shuffler unit, unused by the other units.
	typedef struct packed {
		logic                       is_swizzle;
		logic                       is_broadcast;
		gfx_sp_isa_pkg::broadc_imm  imm;
		gfx_sp_isa_pkg::select_mask select_mask;
		gfx_sp_isa_pkg::swizzle_op  swizzle_op;
	} shuf_deco;

	typedef struct packed {
		logic     writeback;
		logic     read_src_a;
		logic     read_src_b;
		ex_unit   ex;
		reg_idx   dst;
		reg_idx   src_a;
		reg_idx   src_b;
		logic     clear_lanes;
		shuf_deco shuffler;
	} insn_deco;

endpackage

// ==== src/gfx_sp_fetch.sv ====
`timescale 1ns/1ps

module gfx_sp_fetch #(
	parameter int IMEM_AW = 6
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     imem_we,
	input  logic [IMEM_AW-1:0]       imem_addr,
	input  gfx_sp_isa_pkg::insn_word imem_wdata,
	input  logic                     start,
	input  logic [IMEM_AW:0]         prog_len,
	output logic                     busy,
	output gfx_sp_isa_pkg::insn_word insn,
	output logic                     insn_valid,
	input  logic                     insn_ready
);
	import gfx_sp_isa_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_drain
	} fetch_state;

	fetch_state state;
	insn_word imem [2**IMEM_AW];
	logic [IMEM_AW:0] pc;  // Next address to read.
	logic [IMEM_AW:0] pc_next;
	logic [IMEM_AW:0] len;
	logic [IMEM_AW-1:0] rd_addr;
	logic rd_en;

	assign pc_next = pc + (IMEM_AW+1)'(1);

	// The first word is read in the start cycle, later ones on each handshake.
	assign rd_en = (state == st_idle && start && prog_len != '0) ||
		(state == st_run && insn_ready);
	assign rd_addr = (state == st_idle) ? '0 : pc[IMEM_AW-1:0];

	assign insn_valid = state != st_idle;
	assign busy = state != st_idle; // Drops once the last word is taken.

	always_ff @(posedge clk) begin
		if (imem_we)
			imem[imem_addr] <= imem_wdata;
	end

	always_ff @(posedge clk) begin
		if (rd_en)
			insn <= imem[rd_addr]; // Held while the consumer stalls.
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			pc <= '0;
			len <= '0;
		end else begin
			unique case (state)
				st_idle: begin
					if (start && prog_len != '0) begin
						len <= prog_len;
						pc <= (IMEM_AW+1)'(1);
						state <= (prog_len == (IMEM_AW+1)'(1)) ? st_drain : st_run;
					end
				end
				st_run: begin
					if (insn_ready) begin
						pc <= pc_next;
						if (pc_next == len)
							state <= st_drain;
					end
				end
				st_drain: begin
					if (insn_ready)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// ==== src/gfx_skid_buf.sv ====
`timescale 1ns/1ps

// The upstream register is the first entry. The skid register catches the
// item that was already on its way when the output stalled.
module gfx_skid_buf #(
	parameter int WIDTH = 32
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [WIDTH-1:0] in,
	input  logic             in_valid,
	output logic             in_ready,
	output logic [WIDTH-1:0] out,
	output logic             out_valid,
	input  logic             out_ready
);
	logic [WIDTH-1:0] skid;
	logic skid_valid;
	logic capture;

	assign capture = in_valid && in_ready && !out_ready;

	assign in_ready = !skid_valid; // Straight from a flop, no path from out_ready.
	assign out = skid_valid ? skid : in;
	assign out_valid = skid_valid || in_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			skid_valid <= 1'b0;
		else if (capture)
			skid_valid <= 1'b1;
		else if (out_ready)
			skid_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (capture)
			skid <= in;
	end

endmodule

// ==== src/gfx_sp_decode.sv ====
`timescale 1ns/1ps

module gfx_sp_decode (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      clear_lanes,
	input  gfx_sp_isa_pkg::insn_word  insn,
	input  logic                      insn_valid,
	output logic                      insn_ready,
	output gfx_sp_pipe_pkg::insn_deco deco,
	output logic                      deco_valid,
	input  logic                      deco_ready
);
	import gfx_sp_isa_pkg::*;
	import gfx_sp_pipe_pkg::*;

	insn_op opcode;
	insn_deco deco_in;
	insn_deco stage_deco;
	logic stage_valid;
	logic skid_ready;
	logic advance;

	assign opcode = insn_op'(insn[OP_HI:OP_LO]);

	// ========================================
	// Opcode decode
	// ========================================

	always_comb begin
		deco_in.writeback = 1'b0;
		deco_in.read_src_a = 1'b0;
		deco_in.read_src_b = 1'b0;
		deco_in.shuffler.is_swizzle = 1'b0;
		deco_in.shuffler.is_broadcast = 1'b0;

		unique case (opcode)
			SELECT: begin
				deco_in.ex = shuffler;
				deco_in.writeback = 1'b1;
				deco_in.read_src_a = 1'b1;
				deco_in.read_src_b = 1'b1;
			end
			SWIZZL: begin
				deco_in.ex = shuffler;
				deco_in.writeback = 1'b1;
				deco_in.read_src_a = 1'b1;
				deco_in.shuffler.is_swizzle = 1'b1;
			end
			BROADC: begin
				deco_in.ex = shuffler;
				deco_in.writeback = 1'b1;
				deco_in.shuffler.is_broadcast = 1'b1;
			end
			MATVEC: begin
				deco_in.ex = combiner;
				deco_in.writeback = 1'b1;
				deco_in.read_src_a = 1'b1;
				deco_in.read_src_b = 1'b1;
			end
			SEND: begin
				deco_in.ex = stream;
				deco_in.read_src_a = 1'b1;
			end
			RECV: begin
				deco_in.ex = stream;
				deco_in.writeback = 1'b1;
			end
			default: deco_in = 'x; // Undefined opcodes leave synthesis free.
		endcase

		// Fields are extracted whatever the opcode.
		deco_in.dst = insn[DST_HI:DST_LO];
		deco_in.src_a = insn[SRC_A_HI:SRC_A_LO];
		deco_in.src_b = insn[SRC_B_HI:SRC_B_LO];
		deco_in.clear_lanes = clear_lanes;
		deco_in.shuffler.imm = insn[IMM_HI:IMM_LO];
		deco_in.shuffler.select_mask = insn[MASK_HI:MASK_LO];
		deco_in.shuffler.swizzle_op = insn[SWZ_HI:SWZ_LO];
	end

	// ========================================
	// Pipeline register and output skid
	// ========================================

	assign advance = !stage_valid || skid_ready;
	assign insn_ready = advance;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			stage_valid <= 1'b0;
		else if (advance)
			stage_valid <= insn_valid;
	end

	always_ff @(posedge clk) begin
		if (advance && insn_valid)
			stage_deco <= deco_in;
	end

	gfx_skid_buf #(
		.WIDTH($bits(insn_deco))
	) u_skid (
		.clk      (clk),
		.rst_n    (rst_n),
		.in       (stage_deco),
		.in_valid (stage_valid),
		.in_ready (skid_ready),
		.out      (deco),
		.out_valid(deco_valid),
		.out_ready(deco_ready)
	);

endmodule

// ==== src/gfx_sp_issue.sv ====
`timescale 1ns/1ps

module gfx_sp_issue #(
	parameter int WB_LATENCY = 3
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  gfx_sp_pipe_pkg::insn_deco deco,
	input  logic                      deco_valid,
	output logic                      deco_ready,
	output gfx_sp_pipe_pkg::insn_deco op,
	output logic                      op_valid,
	input  logic                      op_ready
);
	import gfx_sp_pipe_pkg::*;

	localparam int CNT_W = $clog2(WB_LATENCY + 1);

	logic [CNT_W-1:0] pend [NUM_REGS]; // Cycles left until writeback.
	logic hazard;
	logic slot_free;
	logic take;
	logic retire;

	// A register is busy while its writeback is pending, or while the op held
	// at the output will write it.
	function automatic logic reg_busy(input reg_idx r);
		reg_busy = (pend[r] != '0) || (op_valid && op.writeback && op.dst == r);
	endfunction

	// ========================================
	// Scoreboard check
	// ========================================

	always_comb begin
		hazard = (deco.writeback && reg_busy(deco.dst)) ||
			(deco.read_src_a && reg_busy(deco.src_a)) ||
			(deco.read_src_b && reg_busy(deco.src_b));
	end

	assign slot_free = !op_valid || op_ready;
	assign deco_ready = slot_free && !hazard;
	assign take = deco_valid && deco_ready;
	assign retire = op_valid && op_ready && op.writeback;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				pend[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_REGS; i++) begin
				if (retire && op.dst == reg_idx'(i))
					pend[i] <= CNT_W'(WB_LATENCY); // Countdown starts at the handshake.
				else if (pend[i] != '0)
					pend[i] <= pend[i] - CNT_W'(1);
			end
		end
	end

	// ========================================
	// Output register
	// ========================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			op_valid <= 1'b0;
		else if (slot_free)
			op_valid <= take;
	end

	always_ff @(posedge clk) begin
		if (take)
			op <= deco;
	end

endmodule

// ==== src/gfx_sp_front.sv ====
`timescale 1ns/1ps

module gfx_sp_front #(
	parameter int IMEM_AW    = 6,
	parameter int WB_LATENCY = 3
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      imem_we,
	input  logic [IMEM_AW-1:0]        imem_addr,
	input  gfx_sp_isa_pkg::insn_word  imem_wdata,
	input  logic                      start,
	input  logic [IMEM_AW:0]          prog_len,
	output logic                      busy,
	input  logic                      clear_lanes,
	output gfx_sp_pipe_pkg::insn_deco op,
	output logic                      op_valid,
	input  logic                      op_ready
);
	import gfx_sp_isa_pkg::*;
	import gfx_sp_pipe_pkg::*;

	insn_word insn;
	logic insn_valid;
	logic insn_ready;

	insn_deco deco;
	logic deco_valid;
	logic deco_ready;

	gfx_sp_fetch #(
		.IMEM_AW(IMEM_AW)
	) u_fetch (
		.clk       (clk),
		.rst_n     (rst_n),
		.imem_we   (imem_we),
		.imem_addr (imem_addr),
		.imem_wdata(imem_wdata),
		.start     (start),
		.prog_len  (prog_len),
		.busy      (busy),
		.insn      (insn),
		.insn_valid(insn_valid),
		.insn_ready(insn_ready)
	);

	gfx_sp_decode u_decode (
		.clk        (clk),
		.rst_n      (rst_n),
		.clear_lanes(clear_lanes),
		.insn       (insn),
		.insn_valid (insn_valid),
		.insn_ready (insn_ready),
		.deco       (deco),
		.deco_valid (deco_valid),
		.deco_ready (deco_ready)
	);

	gfx_sp_issue #(
		.WB_LATENCY(WB_LATENCY)
	) u_issue (
		.clk       (clk),
		.rst_n     (rst_n),
		.deco      (deco),
		.deco_valid(deco_valid),
		.deco_ready(deco_ready),
		.op        (op),
		.op_valid  (op_valid),
		.op_ready  (op_ready)
	);

endmodule

// ==== test/gfx_sp_clkgen.sv ====
`timescale 1ns/1ps

module gfx_sp_clkgen #(
	parameter int PERIOD_NS  = 8,
	parameter int RST_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Reset is released on a rising edge after RST_CYCLES edges.
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// ==== test/gfx_sp_tb_ref.svh ====
`ifndef GFX_SP_TB_REF_SVH
`define GFX_SP_TB_REF_SVH

// Operations still expected at the issue output, oldest first.
insn_deco exp_q [$];

// Expected decoded bundle of one instruction, built from the opcode table.
function automatic insn_deco ref_decode(input insn_word w, input logic cl);
	insn_deco d;
	d = '0;
	d.dst = reg_idx'(w[27:24]);
	d.src_a = reg_idx'(w[23:20]);
	d.src_b = reg_idx'(w[19:16]);
	d.clear_lanes = cl;
	d.shuffler.imm = broadc_imm'(w[15:0]);
	d.shuffler.select_mask = select_mask'(w[3:0]);
	d.shuffler.swizzle_op = swizzle_op'(w[7:0]);
	case (insn_op'(w[31:28]))
		SELECT: begin
			d.ex = shuffler;
			d.writeback = 1'b1;
			d.read_src_a = 1'b1;
			d.read_src_b = 1'b1;
		end
		SWIZZL: begin
			d.ex = shuffler;
			d.writeback = 1'b1;
			d.read_src_a = 1'b1;
			d.shuffler.is_swizzle = 1'b1;
		end
		BROADC: begin
			d.ex = shuffler;
			d.writeback = 1'b1;
			d.shuffler.is_broadcast = 1'b1;
		end
		MATVEC: begin
			d.ex = combiner;
			d.writeback = 1'b1;
			d.read_src_a = 1'b1;
			d.read_src_b = 1'b1;
		end
		SEND: begin
			d.ex = stream;
			d.read_src_a = 1'b1;
		end
		default: begin // RECV, the only other opcode that is sent.
			d.ex = stream;
			d.writeback = 1'b1;
		end
	endcase
	return d;
endfunction

function automatic void clear_expected();
	exp_q.delete();
endfunction

function automatic void expect_op(input insn_deco d);
	exp_q.push_back(d);
endfunction

function automatic insn_deco next_expected();
	return exp_q.pop_front();
endfunction

function automatic insn_deco peek_expected();
	return exp_q[0];
endfunction

`endif

// ==== test/gfx_sp_tb.sv ====
`timescale 1ns/1ps

module gfx_sp_tb;
	import gfx_sp_isa_pkg::*;
	import gfx_sp_pipe_pkg::*;

	localparam int IMEM_AW = 6;
	localparam int WB_LATENCY = 3;

	logic clk;
	logic rst_n;
	logic imem_we = 1'b0;
	logic [IMEM_AW-1:0] imem_addr = '0;
	insn_word imem_wdata = '0;
	logic start = 1'b0;
	logic [IMEM_AW:0] prog_len = '0;
	logic busy;
	logic clear_lanes = 1'b0;
	insn_deco op;
	logic op_valid;
	logic op_ready = 1'b0;

	insn_word prog_words [0:63];
	logic cl_tab [0:64];     // Clear_lanes value paired with each instruction.
	int ready_pct = 100;
	int cl_idx = 0;
	int fetched = 0;
	int ops_done = 0;
	logic held = 1'b0;
	longint cycle_cnt = 0;
	longint wb_cycle [NUM_REGS];
	logic wb_seen [NUM_REGS];

	`include "gfx_sp_tb_ref.svh"

	gfx_sp_clkgen #(
		.PERIOD_NS (8),
		.RST_CYCLES(10)
	) u_clkgen (
		.clk  (clk),
		.rst_n(rst_n)
	);

	gfx_sp_front #(
		.IMEM_AW   (IMEM_AW),
		.WB_LATENCY(WB_LATENCY)
	) u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.start      (start),
		.prog_len   (prog_len),
		.busy       (busy),
		.clear_lanes(clear_lanes),
		.op         (op),
		.op_valid   (op_valid),
		.op_ready   (op_ready)
	);

	// ========================================
	// Failure reporting and compare tasks
	// ========================================

	task automatic stop_run();
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic fail_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		stop_run();
	endtask

	task automatic give_up(input string why);
		$display("Timeout at %0t ns: %s", $time, why);
		stop_run();
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_value(name, 32'(got), 32'(exp));
	endtask

	task automatic check_deco(input insn_deco got, input insn_deco exp);
		if (got.writeback !== exp.writeback)
			fail_value("op.writeback", 32'(got.writeback), 32'(exp.writeback));
		if (got.read_src_a !== exp.read_src_a)
			fail_value("op.read_src_a", 32'(got.read_src_a), 32'(exp.read_src_a));
		if (got.read_src_b !== exp.read_src_b)
			fail_value("op.read_src_b", 32'(got.read_src_b), 32'(exp.read_src_b));
		if (got.ex !== exp.ex)
			fail_value("op.ex", 32'(got.ex), 32'(exp.ex));
		if (got.clear_lanes !== exp.clear_lanes)
			fail_value("op.clear_lanes", 32'(got.clear_lanes), 32'(exp.clear_lanes));
		if (got.shuffler.is_swizzle !== exp.shuffler.is_swizzle)
			fail_value("op.is_swizzle", 32'(got.shuffler.is_swizzle),
				32'(exp.shuffler.is_swizzle));
		if (got.shuffler.is_broadcast !== exp.shuffler.is_broadcast)
			fail_value("op.is_broadcast", 32'(got.shuffler.is_broadcast),
				32'(exp.shuffler.is_broadcast));
	endtask

	task automatic check_fields(input insn_deco got, input insn_deco exp);
		if (got.dst !== exp.dst)
			fail_value("op.dst", 32'(got.dst), 32'(exp.dst));
		if (got.src_a !== exp.src_a)
			fail_value("op.src_a", 32'(got.src_a), 32'(exp.src_a));
		if (got.src_b !== exp.src_b)
			fail_value("op.src_b", 32'(got.src_b), 32'(exp.src_b));
		if (got.shuffler.imm !== exp.shuffler.imm)
			fail_value("op.imm", 32'(got.shuffler.imm), 32'(exp.shuffler.imm));
		if (got.shuffler.select_mask !== exp.shuffler.select_mask)
			fail_value("op.select_mask", 32'(got.shuffler.select_mask),
				32'(exp.shuffler.select_mask));
		if (got.shuffler.swizzle_op !== exp.shuffler.swizzle_op)
			fail_value("op.swizzle_op", 32'(got.shuffler.swizzle_op),
				32'(exp.shuffler.swizzle_op));
	endtask

	// A register written by an earlier op must have had WB_LATENCY cycles.
	task automatic check_gap(input string what, input reg_idx r);
		if (wb_seen[r] && cycle_cnt - wb_cycle[r] <= longint'(WB_LATENCY)) begin
			$display("Op reading or writing r%0d as %s showed up %0d cycles after its writer",
				r, what, cycle_cnt - wb_cycle[r]);
			stop_run();
		end
	endtask

	task automatic check_spacing(input insn_deco e);
		if (e.writeback)
			check_gap("dst", e.dst);
		if (e.read_src_a)
			check_gap("src_a", e.src_a);
		if (e.read_src_b)
			check_gap("src_b", e.src_b);
	endtask

	// ========================================
	// Background processes
	// ========================================

	always @(posedge clk) begin
		op_ready <= ($urandom % 100) < ready_pct;
	end

	// Each instruction gets its clear_lanes value while it waits at decode.
	always @(posedge clk) begin
		if (start) begin
			cl_idx = 0;
			clear_lanes <= cl_tab[0];
			fetched <= 0;
		end else if (u_dut.insn_valid && u_dut.insn_ready) begin
			cl_idx = cl_idx + 1;
			clear_lanes <= cl_tab[cl_idx];
			fetched <= fetched + 1;
		end
	end

	always @(posedge clk) begin : compare_ops
		insn_deco exp_op;
		cycle_cnt = cycle_cnt + 1;
		if (start) begin
			clear_expected();
			for (int i = 0; i < int'(prog_len); i++)
				expect_op(ref_decode(prog_words[i], cl_tab[i]));
			ops_done <= 0;
		end
		if (op_valid && !held) begin
			if (exp_q.size() == 0) begin
				$display("An operation appeared at %0t ns with none expected", $time);
				stop_run();
			end
			check_spacing(peek_expected());
		end
		if (op_valid && op_ready) begin
			exp_op = next_expected();
			check_deco(op, exp_op);
			check_fields(op, exp_op);
			if (exp_op.writeback) begin
				wb_cycle[exp_op.dst] = cycle_cnt;
				wb_seen[exp_op.dst] = 1'b1;
			end
			ops_done <= ops_done + 1;
		end
		held = op_valid && !op_ready;
	end

	// ========================================
	// Programs
	// ========================================

	function automatic insn_op op_at(input int k);
		case (k)
			0: return SELECT;
			1: return SWIZZL;
			2: return BROADC;
			3: return MATVEC;
			4: return SEND;
			default: return RECV;
		endcase
	endfunction

	task automatic build_mixed(input int n);
		insn_word w;
		for (int i = 0; i < n; i++) begin
			w = $urandom();
			w[31:28] = op_at((i < 6) ? i : int'($urandom % 6));
			prog_words[i] = w;
			cl_tab[i] = 1'($urandom());
		end
	endtask

	task automatic build_independent();
		insn_word w;
		for (int i = 0; i < 16; i++) begin
			w = $urandom();
			w[31:28] = (i % 2 == 1) ? RECV : BROADC; // Neither reads a source.
			w[27:24] = 4'(i);
			prog_words[i] = w;
			cl_tab[i] = 1'($urandom());
		end
	endtask

	// Every op reads the register written by the op before it.
	task automatic build_chain(input int n);
		insn_op opc;
		for (int i = 0; i < n; i++) begin
			opc = (i == n - 1) ? SEND : op_at((i % 3 == 2) ? 3 : i % 3);
			prog_words[i] = {opc, 4'(i + 1), 4'(i), 4'(i), 16'($urandom())};
			cl_tab[i] = 1'($urandom());
		end
	endtask

	task automatic run_program(input int len, input int pct);
		int t;
		ready_pct = pct;
		for (int i = 0; i < len; i++) begin
			@(posedge clk);
			imem_we <= 1'b1;
			imem_addr <= IMEM_AW'(i);
			imem_wdata <= prog_words[i];
		end
		@(posedge clk);
		imem_we <= 1'b0;
		start <= 1'b1;
		prog_len <= (IMEM_AW + 1)'(len);
		@(posedge clk);
		start <= 1'b0;
		@(posedge clk);
		check_level("busy", busy, 1'b1);
		t = 0;
		while (busy) begin
			if (fetched == len) begin
				$display("busy was still high after all %0d instructions left fetch", len);
				stop_run();
			end
			@(posedge clk);
			t++;
			if (t > 2000)
				give_up("fetch never finished the program");
		end
		if (fetched != len) begin
			$display("busy fell after %0d of %0d instructions left fetch", fetched, len);
			stop_run();
		end
		t = 0;
		while (ops_done != len) begin
			@(posedge clk);
			t++;
			if (t > 4000)
				give_up("not every operation left the issue stage");
		end
		check_level("op_valid", op_valid, 1'b0);
	endtask

	initial begin : main
		int t;
		void'($urandom(88990));
		t = 0;
		while (!rst_n) begin
			@(posedge clk);
			t++;
			if (t > 100)
				give_up("reset was never released");
		end
		repeat (20) begin
			@(posedge clk);
			check_level("op_valid", op_valid, 1'b0);
			check_level("busy", busy, 1'b0);
		end

		build_mixed(24);
		run_program(24, 60);
		build_independent();
		run_program(16, 100);
		build_chain(14);
		run_program(14, 100);
		build_chain(14);
		run_program(14, 40);
		build_mixed(40);
		run_program(40, 30);

		@(posedge clk);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+test
src/gfx_sp_isa_pkg.sv
src/gfx_sp_pipe_pkg.sv
src/gfx_sp_fetch.sv
src/gfx_skid_buf.sv
src/gfx_sp_decode.sv
src/gfx_sp_issue.sv
src/gfx_sp_front.sv
test/gfx_sp_clkgen.sv
test/gfx_sp_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f files.f --top-module gfx_sp_tb -o gfx_sp_sim \
	&& { ./obj_dir/gfx_sp_sim > sim.log 2>&1 || true; } \
	|| { echo "Verilator build failed"; exit 1; }
grep -q -F '*** PASSED ***' sim.log \
	&& echo "Simulation passed, see sim.log" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
